//--- flist.f
design/mole_pkg.sv
design/hit_judge.sv
design/mole_spawner.sv
design/hammer_window.sv
design/score_keeper.sv
design/end_screen_blinker.sv
design/game_control.sv
design/whack_a_mole_top.sv
tb/tb_whack_a_mole.sv

//--- Bender.yml
package:
  name: whack_a_mole

sources:
  - design/mole_pkg.sv
  - design/hit_judge.sv
  - design/mole_spawner.sv
  - design/hammer_window.sv
  - design/score_keeper.sv
  - design/end_screen_blinker.sv
  - design/game_control.sv
  - design/whack_a_mole_top.sv
  - target: simulation
    files:
      - tb/tb_whack_a_mole.sv

//--- tb/tb_whack_a_mole.sv
`default_nettype none

module tb_whack_a_mole import mole_pkg::*; ();

    localparam int STIM_DELAY = 10;
    localparam int SPAWN_MAX  = SPAWN_MIN + 15;
    localparam int WAIT_LIMIT = 100;
    localparam int MOLE_LIMIT = 400;

    logic         clk;
    logic         reset;
    mole_vec_t    buttons;
    mole_vec_t    moles;
    game_status_t status;

    int unsigned lcg_state;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    int          hole;
    int          pick;
    int          games;
    int          moles_seen;
    bit          miss_ok;

    // Model of the game
    game_state_t m_state;
    int          m_score;
    int          m_lives;
    int          m_high;

    always #50 clk = ~clk;

    whack_a_mole_top u_dut (
        .clk     (clk),
        .reset   (reset),
        .buttons (buttons),
        .moles   (moles),
        .status  (status)
    );

    ////////////////////
    // Helpers
    ////////////////////

    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    function automatic int rand_below(input int n);
        return int'(next_rand() % n);
    endfunction

    // Window length at the current model level
    function automatic int window_len();
        int lvl;
        lvl = m_score / POINTS_PER_LEVEL;
        if (lvl > MAX_LEVEL) begin
            lvl = MAX_LEVEL;
        end
        return HAMMER_WINDOW - lvl * HAMMER_STEP;
    endfunction

    // Drive point and output sample point
    task automatic tick();
        @(posedge clk);
        #STIM_DELAY;
    endtask

    // One low sample first so the press is always a rising edge
    task automatic press(input int idx);
        tick();
        buttons = mole_vec_t'(1) << idx;
        tick();
        buttons = '0;
    endtask

    task automatic check_status(input string tag);
        int exp_score;
        // Score port shows the high score during game over
        exp_score = (m_state == ST_OVER) ? m_high : m_score;
        assert (status.state == m_state) else begin
            $display("Mismatch at %0t: %s, state %0d, expected %0d",
                     $time, tag, status.state, m_state);
            errors++;
        end
        assert (status.score == exp_score) else begin
            $display("Mismatch at %0t: %s, score %0d, expected %0d",
                     $time, tag, status.score, exp_score);
            errors++;
        end
        assert (status.lives == m_lives) else begin
            $display("Mismatch at %0t: %s, lives %0d, expected %0d",
                     $time, tag, status.lives, m_lives);
            errors++;
        end
    endtask

    task automatic check_dark(input string tag);
        assert (moles == '0) else begin
            $display("Mismatch at %0t: %s, moles %b, expected all dark", $time, tag, moles);
            errors++;
        end
    endtask

    task automatic lose_life();
        m_lives--;
        if (m_lives == 0) begin
            m_state = ST_OVER;
            if (m_score > m_high) begin
                m_high = m_score;
            end
        end
    endtask

    task automatic start_game();
        press(rand_below(NUM_MOLES));
        m_state = ST_PLAY;
        m_score = 0;
        m_lives = START_LIVES;
        check_status("game start");
        check_dark("game start");
    endtask

    task automatic return_to_idle();
        press(rand_below(NUM_MOLES));
        m_state = ST_IDLE;
        check_status("return to idle");
        check_dark("return to idle");
    endtask

    // Called right after the spawner was armed
    task automatic wait_for_mole(input bit dark_presses, output int lit_hole);
        int n;
        n = 0;
        lit_hole = -1;
        while (moles == '0 && n < WAIT_LIMIT) begin
            // Presses on a dark board only before a mole can show
            if (dark_presses && n < SPAWN_MIN - 2 && rand_below(4) == 0) begin
                press(rand_below(NUM_MOLES));
                n += 2;
            end else begin
                tick();
                n++;
            end
        end
        if (moles == '0) begin
            $display("Timeout: no mole lit within %0d cycles at %0t", WAIT_LIMIT, $time);
            errors++;
        end else begin
            assert ($countones(moles) == 1) else begin
                $display("Mismatch at %0t: moles %b, expected one lit", $time, moles);
                errors++;
            end
            assert (n >= SPAWN_MIN && n <= SPAWN_MAX) else begin
                $display("Mismatch at %0t: spawn after %0d cycles, expected %0d to %0d",
                         $time, n, SPAWN_MIN, SPAWN_MAX);
                errors++;
            end
            for (int i = 0; i < NUM_MOLES; i++) begin
                if (moles[i]) begin
                    lit_hole = i;
                end
            end
            check_status("mole lit");
        end
    endtask

    task automatic hit_mole(input int lit_hole);
        int k;
        // Press lands no later than the last window cycle
        k = rand_below(window_len() - 2);
        repeat (k) tick();
        press(lit_hole);
        m_score++;
        if (m_score == WIN_SCORE) begin
            m_state = ST_WIN;
        end
        check_status("hit");
        check_dark("hit");
    endtask

    task automatic wrong_press(input int lit_hole);
        int other;
        other = (lit_hole + 1 + rand_below(NUM_MOLES - 1)) % NUM_MOLES;
        press(other);
        lose_life();
        check_status("wrong press");
        check_dark("wrong press");
    endtask

    task automatic let_expire();
        int len;
        int n;
        len = window_len();
        n = 0;
        while (status.lives == m_lives && n < HAMMER_WINDOW + 10) begin
            tick();
            n++;
        end
        if (status.lives == m_lives) begin
            $display("Timeout: hammer window never expired at %0t", $time);
            errors++;
        end else begin
            assert (n == len) else begin
                $display("Mismatch at %0t: window %0d cycles, expected %0d", $time, n, len);
                errors++;
            end
        end
        lose_life();
        check_status("expiry");
        check_dark("expiry");
    endtask

    // Light i flips every (i+1)*BLINK_BASE cycles from game-over entry
    task automatic check_blink(input int cycles);
        mole_vec_t expected;
        for (int m = 0; m < cycles; m++) begin
            for (int i = 0; i < NUM_MOLES; i++) begin
                expected[i] = ((m / ((i + 1) * BLINK_BASE)) % 2) == 1;
            end
            assert (moles == expected) else begin
                $display("Mismatch at %0t: blink %b, expected %b", $time, moles, expected);
                errors++;
            end
            tick();
        end
    endtask

    task automatic begin_test();
        test_errors = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors > test_errors) begin
            tests_failed++;
            $display("Test %s: FAILED with %0d errors", name, errors - test_errors);
        end else begin
            $display("Test %s: ok", name);
        end
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        lcg_state    = 9487;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        clk          = 1'b0;
        buttons      = '0;
        reset        = 1'b1;
        m_state      = ST_IDLE;
        m_score      = 0;
        m_lives      = 0;
        m_high       = 0;
        repeat (5) @(posedge clk);
        #STIM_DELAY;
        reset = 1'b0;

        // Reset values and the first game
        begin_test();
        check_status("after reset");
        check_dark("after reset");
        start_game();
        end_test("reset and start");

        begin_test();
        repeat (3) begin
            wait_for_mole(1'b0, hole);
            if (hole >= 0) begin
                hit_mole(hole);
            end
        end
        end_test("hits");

        // A wrong press and a level-0 miss before a level-1 miss ends the game
        begin_test();
        wait_for_mole(1'b0, hole);
        if (hole >= 0) begin
            wrong_press(hole);
        end
        wait_for_mole(1'b0, hole);
        let_expire();
        while (m_score < POINTS_PER_LEVEL && errors == test_errors) begin
            wait_for_mole(1'b0, hole);
            if (hole >= 0) begin
                hit_mole(hole);
            end
        end
        wait_for_mole(1'b0, hole);
        let_expire();
        end_test("misses and level window");

        begin_test();
        check_status("game over");
        check_blink(600);
        return_to_idle();
        end_test("game over");

        // Long random game restarted after each loss until a win
        begin_test();
        start_game();
        games = 0;
        moles_seen = 0;
        while (m_state != ST_WIN && moles_seen < MOLE_LIMIT) begin
            if (m_state == ST_OVER) begin
                return_to_idle();
                start_game();
                games++;
            end
            wait_for_mole(1'b1, hole);
            if (hole < 0) begin
                break;
            end
            moles_seen++;
            // Early games may be lost and the last one keeps a life
            miss_ok = (games < 2) || (m_lives > 1);
            pick = rand_below(8);
            // First game ends on wrong presses below the high score
            if (games == 0 || (miss_ok && pick == 0)) begin
                wrong_press(hole);
            end else if (miss_ok && pick == 1) begin
                let_expire();
            end else begin
                hit_mole(hole);
            end
        end
        assert (m_state == ST_WIN) else begin
            $display("Long game did not reach a win after %0d moles", moles_seen);
            errors++;
        end
        // Win ignores further presses
        repeat (3) begin
            press(rand_below(NUM_MOLES));
            check_status("after win");
            check_dark("after win");
        end
        end_test("long game to win");

        $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- design/whack_a_mole_top.sv
`default_nettype none

module whack_a_mole_top import mole_pkg::*; (
    input  wire          clk,
    input  wire          reset,
    input  mole_vec_t    buttons,
    output mole_vec_t    moles,
    output game_status_t status
);

    ////////////////////
    // Interconnect
    ////////////////////

    judge_t             judge;
    mole_vec_t          lit;
    mole_vec_t          pattern;
    logic               start_game;
    logic               arm_spawn;
    logic               clear_mole;
    logic               open_window;
    logic               clear_window;
    logic               playing;
    logic               game_over;
    logic               spawned;
    logic               expired;
    logic               won;
    logic               out_of_lives;
    logic [SCORE_W-1:0] score;
    logic [LIVES_W-1:0] lives;
    logic [2:0]         level;

    // Sequencing and output muxing
    game_control u_game_control (
        .clk          (clk),
        .reset        (reset),
        .judge        (judge),
        .spawned      (spawned),
        .expired      (expired),
        .won          (won),
        .out_of_lives (out_of_lives),
        .lit          (lit),
        .pattern      (pattern),
        .score        (score),
        .lives        (lives),
        .start_game   (start_game),
        .arm_spawn    (arm_spawn),
        .clear_mole   (clear_mole),
        .open_window  (open_window),
        .clear_window (clear_window),
        .playing      (playing),
        .game_over    (game_over),
        .moles        (moles),
        .status       (status)
    );

    // Button edges against the lit hole
    hit_judge u_hit_judge (
        .clk     (clk),
        .reset   (reset),
        .buttons (buttons),
        .lit     (lit),
        .playing (playing),
        .judge   (judge)
    );

    mole_spawner u_mole_spawner (
        .clk        (clk),
        .reset      (reset),
        .playing    (playing),
        .arm_spawn  (arm_spawn),
        .clear_mole (clear_mole),
        .lit        (lit),
        .spawned    (spawned)
    );

    hammer_window u_hammer_window (
        .clk          (clk),
        .reset        (reset),
        .playing      (playing),
        .open_window  (open_window),
        .level        (level),
        .clear_window (clear_window),
        .expired      (expired)
    );

    score_keeper u_score_keeper (
        .clk          (clk),
        .reset        (reset),
        .start_game   (start_game),
        .playing      (playing),
        .game_over    (game_over),
        .judge        (judge),
        .expired      (expired),
        .score        (score),
        .lives        (lives),
        .level        (level),
        .won          (won),
        .out_of_lives (out_of_lives)
    );

    // Game-over light show
    end_screen_blinker u_end_screen_blinker (
        .clk        (clk),
        .reset      (reset),
        .game_over  (game_over),
        .start_game (start_game),
        .pattern    (pattern)
    );

endmodule

`default_nettype wire

//--- design/game_control.sv
`default_nettype none

module game_control import mole_pkg::*; (
    input  wire                clk,
    input  wire                reset,
    input  judge_t             judge,
    input  wire                spawned,
    input  wire                expired,
    input  wire                won,
    input  wire                out_of_lives,
    input  mole_vec_t          lit,
    input  mole_vec_t          pattern,
    input  wire  [SCORE_W-1:0] score,
    input  wire  [LIVES_W-1:0] lives,
    output logic               start_game,
    output logic               arm_spawn,
    output logic               clear_mole,
    output logic               open_window,
    output logic               clear_window,
    output logic               playing,
    output logic               game_over,
    output mole_vec_t          moles,
    output game_status_t       status
);

    game_state_t state;
    game_state_t state_next;
    logic        resolve;

    ////////////////////
    // Decoded levels
    ////////////////////

    assign playing   = (state == ST_PLAY);
    assign game_over = (state == ST_OVER);

    // Mole resolved by hit, wrong press or timeout
    assign resolve = playing && (judge.hit || judge.wrong || expired);

    ////////////////////
    // Command pulses
    ////////////////////

    assign start_game   = (state == ST_IDLE) && judge.any_press;
    assign clear_mole   = resolve;
    assign clear_window = resolve;
    // No new window if the mole was already hit on its first cycle
    assign open_window  = playing && spawned && !resolve;
    // Re-arm only when the game carries on
    assign arm_spawn    = start_game || (resolve && !won && !out_of_lives);

    ////////////////////
    // FSM
    ////////////////////

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (judge.any_press) begin
                    state_next = ST_PLAY;
                end
            end
            ST_PLAY: begin
                // Win and loss never coincide since a hit costs no life
                if (won) begin
                    state_next = ST_WIN;
                end else if (out_of_lives) begin
                    state_next = ST_OVER;
                end
            end
            ST_OVER: begin
                if (judge.any_press) begin
                    state_next = ST_IDLE;
                end
            end
            // Win holds until reset
            ST_WIN:  state_next = ST_WIN;
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    ////////////////////
    // Outputs
    ////////////////////

    // Lit mole in play, blink show at game over, dark otherwise
    always_comb begin
        case (state)
            ST_PLAY: moles = lit;
            ST_OVER: moles = pattern;
            default: moles = '0;
        endcase
    end

    assign status = '{score: score, lives: lives, state: state};

endmodule

`default_nettype wire

//--- design/end_screen_blinker.sv
`default_nettype none

module end_screen_blinker import mole_pkg::*; (
    input  wire       clk,
    input  wire       reset,
    input  wire       game_over,
    input  wire       start_game,
    output mole_vec_t pattern
);

    logic [TIMER_W-1:0] count [NUM_MOLES];

    ////////////////////
    // Blink counters
    ////////////////////

    // Each light has its own period, so the pattern drifts
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pattern <= '0;
            for (int i = 0; i < NUM_MOLES; i++) begin
                count[i] <= '0;
            end
        end else if (start_game) begin
            pattern <= '0;
            for (int i = 0; i < NUM_MOLES; i++) begin
                count[i] <= '0;
            end
        end else if (game_over) begin
            for (int i = 0; i < NUM_MOLES; i++) begin
                // Wrap at (i+1)*BLINK_BASE and flip the light
                if (count[i] == TIMER_W'((i + 1) * BLINK_BASE - 1)) begin
                    count[i]   <= '0;
                    pattern[i] <= ~pattern[i];
                end else begin
                    count[i] <= count[i] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- design/score_keeper.sv
`default_nettype none

module score_keeper import mole_pkg::*; (
    input  wire                clk,
    input  wire                reset,
    input  wire                start_game,
    input  wire                playing,
    input  wire                game_over,
    input  judge_t             judge,
    input  wire                expired,
    output logic [SCORE_W-1:0] score,
    output logic [LIVES_W-1:0] lives,
    output logic [2:0]         level,
    output logic               won,
    output logic               out_of_lives
);

    logic [SCORE_W-1:0] score_q;
    logic [SCORE_W-1:0] high_q;
    logic [SCORE_W-1:0] best;
    logic [SCORE_W-1:0] level_raw;
    logic               add_point;
    logic               lose_life;

    // Hit beats wrong press and timeout
    assign add_point = playing && judge.hit;
    assign lose_life = playing && !judge.hit && (judge.wrong || expired);

    // Game-ending events in the same cycle as the press
    assign won          = add_point && (score_q == SCORE_W'(WIN_SCORE - 1));
    assign out_of_lives = lose_life && (lives == LIVES_W'(1));

    ////////////////////
    // Difficulty level
    ////////////////////

    assign level_raw = score_q / SCORE_W'(POINTS_PER_LEVEL);
    assign level     = (level_raw > SCORE_W'(MAX_LEVEL)) ? 3'(MAX_LEVEL) : level_raw[2:0];

    // High score including the game just ended
    assign best  = (score_q > high_q) ? score_q : high_q;
    assign score = game_over ? best : score_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            score_q <= '0;
            lives   <= '0;
            high_q  <= '0;
        end else begin
            if (start_game) begin
                score_q <= '0;
                lives   <= LIVES_W'(START_LIVES);
            end else if (add_point) begin
                score_q <= score_q + 1'b1;
            end else if (lose_life) begin
                lives <= lives - 1'b1;
            end
            // Fold into high score at game over
            if (game_over) begin
                high_q <= best;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/hammer_window.sv
`default_nettype none

module hammer_window import mole_pkg::*; (
    input  wire       clk,
    input  wire       reset,
    input  wire       playing,
    input  wire       open_window,
    input  wire [2:0] level,
    input  wire       clear_window,
    output logic      expired
);

    logic [TIMER_W-1:0] window_len;
    logic [TIMER_W-1:0] count;
    logic               active;

    // One step shorter per level
    assign window_len = TIMER_W'(HAMMER_WINDOW) - TIMER_W'(level) * TIMER_W'(HAMMER_STEP);

    // Mole missed on the last window cycle
    assign expired = active && (count == TIMER_W'(1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count  <= '0;
            active <= 1'b0;
        end else begin
            if (open_window) begin
                // Spawn cycle already counts as one window cycle
                count  <= window_len - 1'b1;
                active <= 1'b1;
            end else if (clear_window || expired || !playing) begin
                active <= 1'b0;
            end else if (active) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/mole_spawner.sv
`default_nettype none

module mole_spawner import mole_pkg::*; (
    input  wire       clk,
    input  wire       reset,
    input  wire       playing,
    input  wire       arm_spawn,
    input  wire       clear_mole,
    output mole_vec_t lit,
    output logic      spawned
);

    logic [TIMER_W-1:0] lfsr;
    logic               feedback;
    logic [TIMER_W-1:0] delay;
    logic [TIMER_W-1:0] count;
    logic               armed;
    logic [1:0]         mole_sel;

    ////////////////////
    // Random source
    ////////////////////

    // Maximal-length taps x^16 + x^14 + x^13 + x^11
    assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr <= LFSR_SEED;
        end else begin
            lfsr <= {lfsr[TIMER_W-2:0], feedback};
        end
    end

    // Minimum wait plus 0 to 15 random cycles
    assign delay    = TIMER_W'(SPAWN_MIN) + (lfsr & SPAWN_SPAN_MASK);
    // Hole picked from bits outside the delay mask
    assign mole_sel = lfsr[5:4];

    ////////////////////
    // Countdown and lit mole
    ////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count   <= '0;
            armed   <= 1'b0;
            lit     <= '0;
            spawned <= 1'b0;
        end else begin
            spawned <= 1'b0;
            if (clear_mole || !playing) begin
                lit <= '0;
            end
            if (arm_spawn) begin
                count <= delay;
                armed <= 1'b1;
            end else if (!playing) begin
                armed <= 1'b0;
            end else if (armed) begin
                // Mole shows delay edges after arming
                if (count == TIMER_W'(1)) begin
                    armed   <= 1'b0;
                    lit     <= mole_vec_t'(1) << mole_sel;
                    spawned <= 1'b1;
                end
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/hit_judge.sv
`default_nettype none

module hit_judge import mole_pkg::*; (
    input  wire       clk,
    input  wire       reset,
    input  mole_vec_t buttons,
    input  mole_vec_t lit,
    input  wire       playing,
    output judge_t    judge
);

    mole_vec_t prev;
    mole_vec_t rise;
    logic      mole_up;

    // Previous button sample
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prev <= '0;
        end else begin
            prev <= buttons;
        end
    end

    // High now, low last cycle
    assign rise = buttons & ~prev;

    // Presses only count against a lit mole in play
    assign mole_up = playing && (|lit);

    // Any press counts in every state to leave idle and game over
    assign judge.any_press = |rise;
    // Hit wins over a simultaneous wrong press
    assign judge.hit       = mole_up && (|(rise & lit));
    assign judge.wrong     = mole_up && !judge.hit && (|(rise & ~lit));

endmodule

`default_nettype wire

//--- design/mole_pkg.sv
`default_nettype none

package mole_pkg;

    ////////////////////
    // Game sizes
    ////////////////////

    localparam int NUM_MOLES = 4;
    localparam int SCORE_W   = 7;
    localparam int LIVES_W   = 2;
    // Shared width of all timers and counters
    localparam int TIMER_W   = 16;

    ////////////////////
    // Game rules
    ////////////////////

    localparam int START_LIVES      = 3;
    localparam int WIN_SCORE        = 64;
    localparam int POINTS_PER_LEVEL = 8;
    localparam int MAX_LEVEL        = 7;

    // Hammer window at level 0 and its shrink per level
    localparam int HAMMER_WINDOW = 200;
    localparam int HAMMER_STEP   = 20;

    // Spawn delay is SPAWN_MIN plus masked LFSR bits
    localparam int SPAWN_MIN = 20;
    localparam logic [TIMER_W-1:0] SPAWN_SPAN_MASK = 16'h000F;
    localparam logic [TIMER_W-1:0] LFSR_SEED       = 16'hACE1;

    // Light i toggles every (i+1)*BLINK_BASE cycles
    localparam int BLINK_BASE = 50;

    ////////////////////
    // Types
    ////////////////////

    // Fixed 3-bit codes shown on the status port
    typedef enum logic [2:0] {
        ST_IDLE = 3'd0,
        ST_PLAY = 3'd1,
        ST_WIN  = 3'd4,
        ST_OVER = 3'd7
    } game_state_t;

    // One bit per hole
    typedef logic [NUM_MOLES-1:0] mole_vec_t;

    // Press classification for the current cycle
    typedef struct packed {
        logic any_press;
        logic hit;
        logic wrong;
    } judge_t;

    // Top-level status word
    typedef struct packed {
        logic [SCORE_W-1:0] score;
        logic [LIVES_W-1:0] lives;
        game_state_t        state;
    } game_status_t;

endpackage

`default_nettype wire
